//--- source/mc_pkg.sv
// shared widths, address fields, register offsets and bus types for the motor controller core
package mc_pkg;

    // ------------------------------------------------------------
    // widths and constants
    // ------------------------------------------------------------
    localparam int DATA_W   = 32;               // register data
    localparam int ADDR_W   = 16;               // register address
    localparam int CUR_W    = 16;               // adc / command current
    localparam int NUM_AXES = 4;

    localparam logic [15:0] SAFETY_MARGIN = 16'd64;  // adc counts above 2x cmd
    localparam logic [2:0]  SAFETY_COUNT  = 3'd4;    // consecutive cycles to trip
    localparam logic [2:0]  RT_LAST_WORD  = 3'd4;    // words 0..3 axis cmds, 4 status

    // status word bit positions
    localparam int STAT_AMP_EN_LSB   = 0;       // 4 amp enables
    localparam int STAT_AMP_MASK_LSB = 8;       // 4 amp masks, write side only
    localparam int STAT_PWR_EN_BIT   = 16;
    localparam int STAT_PWR_MASK_BIT = 17;
    localparam int STAT_SAFETY_LSB   = 20;      // latched safety disables
    localparam int STAT_BOARD_ID_LSB = 24;

    // ------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'd0                        // only decoded space
    } addr_space_e;

    typedef enum logic [3:0] {
        OFF_STATUS   = 4'd0,                    // channel 0 only
        OFF_ADC_DATA = 4'd1,
        OFF_CMD_CUR  = 4'd2
    } reg_off_e;

    typedef struct packed {
        addr_space_e space;                     // bits 15..12
        logic [3:0]  unused;                    // bits 11..8
        logic [3:0]  chan;                      // 0 board, 1..4 axes
        reg_off_e    off;                       // bits 3..0
    } reg_addr_t;

    typedef struct packed {
        logic              wen;                 // one-cycle write strobe
        reg_addr_t         waddr;
        logic [DATA_W-1:0] wdata;
    } wbus_t;

    // axis n lives in element n-1
    typedef logic [NUM_AXES-1:0][CUR_W-1:0] cur_vec_t;

    typedef enum logic {
        RT_IDLE   = 1'b0,
        RT_REPLAY = 1'b1
    } rt_state_e;

endpackage

//--- source/rt_block_writer.sv
// captures a five-word real-time block and replays it onto the write bus, else passes host writes
`timescale 1ns/1ps

module rt_block_writer (
    input  logic                      sysclk,
    input  logic                      rst,
    input  logic                      rt_wen,      // one-cycle word strobe
    input  logic [2:0]                rt_waddr,    // word index 0..4
    input  logic [mc_pkg::DATA_W-1:0] rt_wdata,
    input  mc_pkg::wbus_t             host_wbus,   // host side of the bus
    output mc_pkg::wbus_t             wbus         // merged write bus
);
    import mc_pkg::*;

    logic [DATA_W-1:0] rt_buf [0:RT_LAST_WORD];   // block words 0..4
    rt_state_e         state;
    logic [2:0]        rep_idx;                   // word being replayed
    logic [3:0]        rep_chan;
    reg_off_e          rep_off;
    logic [ADDR_W-1:0] rep_addr;

    // ------------------------------------------------------------
    // capture side
    // ------------------------------------------------------------
    // strobes while replaying are dropped
    always_ff @(posedge sysclk) begin
        if (state == RT_IDLE && rt_wen && rt_waddr <= RT_LAST_WORD) begin
            rt_buf[rt_waddr] <= rt_wdata;
        end
    end

    // ------------------------------------------------------------
    // replay sequencer
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            state   <= RT_IDLE;
            rep_idx <= '0;
        end else begin
            case (state)
                RT_IDLE: begin
                    if (rt_wen && rt_waddr == RT_LAST_WORD) begin
                        state   <= RT_REPLAY;   // replay starts next cycle
                        rep_idx <= '0;
                    end
                end
                RT_REPLAY: begin
                    if (rep_idx == RT_LAST_WORD) begin
                        state   <= RT_IDLE;     // status word was the last write
                        rep_idx <= '0;
                    end else begin
                        rep_idx <= rep_idx + 3'd1;
                    end
                end
                default: state <= RT_IDLE;
            endcase
        end
    end

    // words 0..3 go to axis cmd regs, word 4 to the board status reg
    assign rep_chan = (rep_idx == RT_LAST_WORD) ? 4'd0 : ({1'b0, rep_idx} + 4'd1);
    assign rep_off  = (rep_idx == RT_LAST_WORD) ? OFF_STATUS : OFF_CMD_CUR;
    assign rep_addr = {ADDR_MAIN, 4'd0, rep_chan, rep_off};

    // replay owns the merged bus while active
    always_comb begin
        if (state == RT_REPLAY) begin
            wbus.wen   = 1'b1;
            wbus.waddr = reg_addr_t'(rep_addr);
            wbus.wdata = rt_buf[rep_idx];
        end else begin
            wbus = host_wbus;                   // host pass-through
        end
    end

endmodule

//--- source/axis_regs.sv
// current-command registers of the four axes, loaded from the merged write bus
`timescale 1ns/1ps

module axis_regs (
    input  logic             sysclk,
    input  logic             rst,
    input  mc_pkg::wbus_t    wbus,        // merged host / real-time bus
    output mc_pkg::cur_vec_t cur_cmd      // axis n at element n-1
);
    import mc_pkg::*;

    logic                cmd_wr;          // cmd offset write in main space
    logic [NUM_AXES-1:0] axis_sel;        // channel decode, one per axis

    // ------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------
    assign cmd_wr = wbus.wen
                 && (wbus.waddr.space == ADDR_MAIN)
                 && (wbus.waddr.off == OFF_CMD_CUR);

    // channel 0 is the board, so axis a sits on channel a+1
    always_comb begin
        for (int a = 0; a < NUM_AXES; a++) begin
            axis_sel[a] = (wbus.waddr.chan == 4'(a + 1));
        end
    end

    // ------------------------------------------------------------
    // command registers
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            cur_cmd <= '0;                // zero command out of reset
        end else begin
            for (int a = 0; a < NUM_AXES; a++) begin
                if (cmd_wr && axis_sel[a]) begin
                    cur_cmd[a] <= wbus.wdata[CUR_W-1:0];   // upper bits ignored
                end
            end
        end
    end

endmodule

//--- source/board_regs.sv
// channel-0 board registers: power and amplifier enables, enable pulses and the status word
`timescale 1ns/1ps

module board_regs (
    input  logic                        sysclk,
    input  logic                        rst,
    input  mc_pkg::wbus_t               wbus,
    input  logic [3:0]                  board_id,        // rotary switch value
    input  logic [mc_pkg::NUM_AXES-1:0] safety_disable,  // from the safety checks
    output logic                        pwr_enable,
    output logic [mc_pkg::NUM_AXES-1:0] amp_enable,      // effective amp enables
    output logic                        pwr_enable_cmd,  // one-cycle pulse
    output logic [mc_pkg::NUM_AXES-1:0] amp_enable_cmd,  // one-cycle pulse per axis
    output logic [mc_pkg::DATA_W-1:0]   status_word
);
    import mc_pkg::*;

    logic                stat_wr;         // status write on channel 0
    logic [NUM_AXES-1:0] amp_en_q;        // requested amp enables
    logic [NUM_AXES-1:0] amp_mask;
    logic [NUM_AXES-1:0] amp_val;

    assign stat_wr = wbus.wen
                  && (wbus.waddr.space == ADDR_MAIN)
                  && (wbus.waddr.chan == 4'd0)
                  && (wbus.waddr.off == OFF_STATUS);

    assign amp_mask = wbus.wdata[STAT_AMP_MASK_LSB +: NUM_AXES];
    assign amp_val  = wbus.wdata[STAT_AMP_EN_LSB +: NUM_AXES];

    // ------------------------------------------------------------
    // enable state and command pulses
    // ------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (rst) begin
            pwr_enable     <= 1'b0;
            amp_en_q       <= '0;
            pwr_enable_cmd <= 1'b0;
            amp_enable_cmd <= '0;
        end else begin
            // masked update, unmasked bits keep their value
            if (stat_wr && wbus.wdata[STAT_PWR_MASK_BIT]) begin
                pwr_enable <= wbus.wdata[STAT_PWR_EN_BIT];
            end
            for (int a = 0; a < NUM_AXES; a++) begin
                if (stat_wr && amp_mask[a]) begin
                    amp_en_q[a] <= amp_val[a];
                end
            end
            // pulse on every enable request, even a repeated one
            pwr_enable_cmd <= stat_wr && wbus.wdata[STAT_PWR_MASK_BIT]
                                      && wbus.wdata[STAT_PWR_EN_BIT];
            amp_enable_cmd <= {NUM_AXES{stat_wr}} & amp_mask & amp_val;
        end
    end

    // amps run only with power on and no safety trip
    assign amp_enable = amp_en_q & {NUM_AXES{pwr_enable}} & ~safety_disable;

    // ------------------------------------------------------------
    // status word, mask bits read back as zero
    // ------------------------------------------------------------
    always_comb begin
        status_word = '0;
        status_word[STAT_AMP_EN_LSB +: NUM_AXES]   = amp_enable;
        status_word[STAT_PWR_EN_BIT]               = pwr_enable;
        status_word[STAT_SAFETY_LSB +: NUM_AXES]   = safety_disable;
        status_word[STAT_BOARD_ID_LSB +: 4]        = board_id;
    end

endmodule

//--- source/safety_check.sv
// per-axis overcurrent check that latches an amplifier disable until cleared
`timescale 1ns/1ps

module safety_check (
    input  logic                     sysclk,
    input  logic                     rst,
    input  logic [mc_pkg::CUR_W-1:0] cur_fb_axis,    // adc feedback
    input  logic [mc_pkg::CUR_W-1:0] cur_cmd_axis,   // commanded current
    input  logic                     clear_disable,  // power or amp enable pulse
    output logic                     amp_disable     // latched trip
);
    import mc_pkg::*;

    logic [CUR_W+1:0] limit;              // 2x cmd + margin, two extra bits
    logic             over_limit;
    logic [2:0]       viol_cnt;           // consecutive over-limit cycles

    assign limit      = {1'b0, cur_cmd_axis, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over_limit = {2'b00, cur_fb_axis} > limit;

    always_ff @(posedge sysclk) begin
        if (rst) begin
            viol_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            viol_cnt    <= '0;            // start counting afresh
            amp_disable <= 1'b0;
        end else if (over_limit) begin
            if (viol_cnt < SAFETY_COUNT) begin
                viol_cnt <= viol_cnt + 3'd1;   // saturates at the trip count
            end
            // this edge closes the last required cycle
            if (viol_cnt >= SAFETY_COUNT - 3'd1) begin
                amp_disable <= 1'b1;
            end
        end else begin
            viol_cnt <= '0;               // streak broken, trip stays latched
        end
    end

endmodule

//--- source/reg_read_mux.sv
// combinational read-address decode selecting status, adc feedback or command read data
`timescale 1ns/1ps

module reg_read_mux (
    input  mc_pkg::reg_addr_t         reg_raddr,
    input  mc_pkg::cur_vec_t          cur_fb,
    input  mc_pkg::cur_vec_t          cur_cmd,
    input  logic [mc_pkg::DATA_W-1:0] status_word,
    output logic [mc_pkg::DATA_W-1:0] reg_rdata
);
    import mc_pkg::*;

    logic [1:0] axis_idx;                 // channel 1..4 to element 0..3

    assign axis_idx = 2'(reg_raddr.chan - 4'd1);

    always_comb begin
        reg_rdata = '0;                   // unused spaces and offsets read zero
        if (reg_raddr.space == ADDR_MAIN) begin
            if (reg_raddr.chan == 4'd0) begin
                if (reg_raddr.off == OFF_STATUS) begin
                    reg_rdata = status_word;
                end
            end else if (reg_raddr.chan <= 4'(NUM_AXES)) begin
                case (reg_raddr.off)
                    OFF_ADC_DATA: reg_rdata = {{(DATA_W-CUR_W){1'b0}}, cur_fb[axis_idx]};
                    OFF_CMD_CUR:  reg_rdata = {{(DATA_W-CUR_W){1'b0}}, cur_cmd[axis_idx]};
                    default:      reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

//--- source/motor_ctrl_top.sv
// top level of the register-bus core, connects the bus merge, registers, safety checks and read mux
`timescale 1ns/1ps

module motor_ctrl_top (
    input  logic                        sysclk,
    input  logic                        rst,
    input  mc_pkg::wbus_t               host_wbus,   // host write bus
    input  mc_pkg::reg_addr_t           reg_raddr,
    output logic [mc_pkg::DATA_W-1:0]   reg_rdata,
    input  logic                        rt_wen,      // real-time block port
    input  logic [2:0]                  rt_waddr,
    input  logic [mc_pkg::DATA_W-1:0]   rt_wdata,
    input  mc_pkg::cur_vec_t            cur_fb,      // adc currents, axes 1..4
    input  logic [3:0]                  board_id,
    output logic                        pwr_enable,
    output logic [mc_pkg::NUM_AXES-1:0] amp_enable
);
    import mc_pkg::*;

    wbus_t               wbus;            // merged write bus
    cur_vec_t            cur_cmd;
    logic [DATA_W-1:0]   status_word;
    logic                pwr_enable_cmd;
    logic [NUM_AXES-1:0] amp_enable_cmd;
    logic [NUM_AXES-1:0] safety_disable;

    // ------------------------------------------------------------
    // write side
    // ------------------------------------------------------------
    rt_block_writer u_rt_write (.sysclk(sysclk), .rst(rst), .rt_wen(rt_wen),
        .rt_waddr(rt_waddr), .rt_wdata(rt_wdata), .host_wbus(host_wbus), .wbus(wbus));

    axis_regs u_axis (.sysclk(sysclk), .rst(rst), .wbus(wbus), .cur_cmd(cur_cmd));

    board_regs u_chan0 (.sysclk(sysclk), .rst(rst), .wbus(wbus), .board_id(board_id),
        .safety_disable(safety_disable), .pwr_enable(pwr_enable), .amp_enable(amp_enable),
        .pwr_enable_cmd(pwr_enable_cmd), .amp_enable_cmd(amp_enable_cmd),
        .status_word(status_word));

    // ------------------------------------------------------------
    // safety checks, fb vs 2x cmd per axis
    // ------------------------------------------------------------
    for (genvar a = 0; a < NUM_AXES; a++) begin : g_safe
        safety_check u_safe (.sysclk(sysclk), .rst(rst), .cur_fb_axis(cur_fb[a]),
            .cur_cmd_axis(cur_cmd[a]), .clear_disable(pwr_enable_cmd | amp_enable_cmd[a]),
            .amp_disable(safety_disable[a]));
    end

    // read side
    reg_read_mux u_rmux (.reg_raddr(reg_raddr), .cur_fb(cur_fb), .cur_cmd(cur_cmd),
        .status_word(status_word), .reg_rdata(reg_rdata));

endmodule

//--- tb/tb_motor_ctrl.sv
// directed testbench for motor_ctrl_top, run through build.f and run_sim.sh
`timescale 1ns/1ps

module tb_motor_ctrl;
    import mc_pkg::*;

    localparam int TIMEOUT = 100;          // cycles allowed per wait

    logic sysclk, rst;
    wbus_t host_wbus;
    reg_addr_t reg_raddr;
    logic [DATA_W-1:0] reg_rdata;
    logic rt_wen;
    logic [2:0] rt_waddr;
    logic [DATA_W-1:0] rt_wdata;
    cur_vec_t cur_fb;
    logic [3:0] board_id;
    logic pwr_enable;
    logic [NUM_AXES-1:0] amp_enable;

    int err_data, err_cur, err_bit, err_timeout;
    integer seed;
    logic [CUR_W-1:0] exp_cmd [1:NUM_AXES];    // model of the cmd registers
    logic exp_pwr;
    logic [NUM_AXES-1:0] exp_amp, exp_safe;     // requested amps, latched trips

    motor_ctrl_top DUT (.sysclk(sysclk), .rst(rst), .host_wbus(host_wbus),
        .reg_raddr(reg_raddr), .reg_rdata(reg_rdata), .rt_wen(rt_wen), .rt_waddr(rt_waddr),
        .rt_wdata(rt_wdata), .cur_fb(cur_fb), .board_id(board_id),
        .pwr_enable(pwr_enable), .amp_enable(amp_enable));

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;           // 8 ns period
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic reg_addr_t make_addr(input logic [3:0] space, input logic [3:0] chan,
            input logic [3:0] off);
        return reg_addr_t'({space, 4'h0, chan, off});
    endfunction

    // host-side status write data
    function automatic logic [DATA_W-1:0] status_cmd(input logic pwr_mask, input logic pwr,
            input logic [3:0] amp_mask, input logic [3:0] amp);
        logic [DATA_W-1:0] w;
        w = '0;
        w[STAT_PWR_MASK_BIT] = pwr_mask;
        w[STAT_PWR_EN_BIT] = pwr;
        w[STAT_AMP_MASK_LSB +: 4] = amp_mask;
        w[STAT_AMP_EN_LSB +: 4] = amp;
        return w;
    endfunction

    // status read-back, amps gated by power and trips
    function automatic logic [DATA_W-1:0] status_expect(input logic [3:0] id, input logic pwr,
            input logic [3:0] amp, input logic [3:0] safe);
        logic [DATA_W-1:0] w;
        w = '0;
        w[STAT_AMP_EN_LSB +: 4] = amp & {4{pwr}} & ~safe;
        w[STAT_PWR_EN_BIT] = pwr;
        w[STAT_SAFETY_LSB +: 4] = safe;
        w[STAT_BOARD_ID_LSB +: 4] = id;
        return w;
    endfunction

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
            input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            err_data++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cur(input string name, input logic [CUR_W-1:0] got,
            input logic [CUR_W-1:0] exp);
        if (got !== exp) begin
            err_cur++;
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_bit++;
            $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    // one-cycle host strobe, returns on the falling edge after the write edge
    task automatic host_write(input logic [3:0] chan, input logic [3:0] off,
            input logic [DATA_W-1:0] data);
        @(negedge sysclk);
        host_wbus.wen = 1'b1;
        host_wbus.waddr = make_addr(ADDR_MAIN, chan, off);
        host_wbus.wdata = data;
        @(negedge sysclk);
        host_wbus.wen = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] space, input logic [3:0] chan,
            input logic [3:0] off, output logic [DATA_W-1:0] data);
        @(negedge sysclk);
        reg_raddr = make_addr(space, chan, off);
        #2 data = reg_rdata;                   // combinational, settled well before posedge
    endtask

    // caller has the status address on reg_raddr
    task automatic wait_status(input int idx, input logic level, input string what,
            output int cycles);
        logic hit;
        hit = 1'b0;
        cycles = 0;
        while (!hit && cycles < TIMEOUT) begin
            @(negedge sysclk);
            #1;
            cycles++;
            hit = (reg_rdata[5'(idx)] === level);
        end
        if (!hit) begin
            err_timeout++;
            $display("timeout: %s not seen within %0d cycles", what, TIMEOUT);
        end
    endtask

    // outputs and status read against the model
    task automatic check_board(input string tag);
        logic [DATA_W-1:0] rd;
        check_bit({tag, " pwr_enable"}, pwr_enable, exp_pwr);
        for (int a = 0; a < NUM_AXES; a++) begin
            check_bit($sformatf("%s amp_enable[%0d]", tag, a), amp_enable[2'(a)],
                exp_amp[2'(a)] & exp_pwr & ~exp_safe[2'(a)]);
        end
        read_reg(ADDR_MAIN, 4'd0, OFF_STATUS, rd);
        check_data({tag, " status"}, rd, status_expect(board_id, exp_pwr, exp_amp, exp_safe));
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_cmd_regs();
        logic [DATA_W-1:0] wd;
        logic [DATA_W-1:0] rd;
        for (int a = 1; a <= NUM_AXES; a++) begin
            wd = $random(seed);                // upper half must be dropped
            exp_cmd[a] = wd[CUR_W-1:0];
            host_write(4'(a), OFF_CMD_CUR, wd);
        end
        for (int a = 1; a <= NUM_AXES; a++) begin
            read_reg(ADDR_MAIN, 4'(a), OFF_CMD_CUR, rd);
            check_data($sformatf("cmd axis %0d", a), rd, {16'h0, exp_cmd[a]});
        end
    endtask

    task automatic test_adc_readback();
        logic [DATA_W-1:0] rd;
        logic [CUR_W-1:0] fb [1:NUM_AXES];
        int lim;
        int val;
        for (int a = 1; a <= NUM_AXES; a++) begin
            lim = 2 * int'(exp_cmd[a]) + int'(SAFETY_MARGIN);
            val = $random(seed) & 32'h7fff_ffff;
            fb[a] = CUR_W'(val % (lim + 1));     // at or under the limit, no trip
        end
        @(negedge sysclk);
        for (int a = 1; a <= NUM_AXES; a++) cur_fb[2'(a - 1)] = fb[a];
        for (int a = 1; a <= NUM_AXES; a++) begin
            read_reg(ADDR_MAIN, 4'(a), OFF_ADC_DATA, rd);
            check_cur($sformatf("adc axis %0d", a), rd[CUR_W-1:0], fb[a]);
            check_cur($sformatf("adc axis %0d upper", a), rd[DATA_W-1:CUR_W], '0);
        end
        read_reg(4'h5, 4'd1, OFF_ADC_DATA, rd);    // space 5 unused
        check_data("adc read in space 5", rd, '0);
        read_reg(4'h3, 4'd0, OFF_STATUS, rd);
        check_data("status read in space 3", rd, '0);
        @(negedge sysclk);
        cur_fb = '0;
    endtask

    task automatic test_board_status();
        host_write(4'd0, OFF_STATUS, status_cmd(1'b1, 1'b1, 4'hf, 4'b0101));
        exp_pwr = 1'b1;
        exp_amp = 4'b0101;
        check_board("power on");
        host_write(4'd0, OFF_STATUS, status_cmd(1'b0, 1'b0, 4'b0010, 4'b0010));
        exp_amp = 4'b0111;                     // masked update keeps the rest
        check_board("amp 2 on");
        host_write(4'd0, OFF_STATUS, status_cmd(1'b1, 1'b0, 4'h0, 4'h0));
        exp_pwr = 1'b0;
        check_board("power off");
        host_write(4'd0, OFF_STATUS, status_cmd(1'b1, 1'b1, 4'h0, 4'h0));
        exp_pwr = 1'b1;
        check_board("power on again");
    endtask

    task automatic test_safety();
        logic seen;
        int cycles;
        host_write(4'd2, OFF_CMD_CUR, 32'd1000);   // limit is 2064
        exp_cmd[2] = 16'd1000;
        @(negedge sysclk);
        cur_fb[1] = 16'd2064;                  // right at the limit
        reg_raddr = make_addr(ADDR_MAIN, 4'd0, OFF_STATUS);
        seen = 1'b0;
        repeat (3 * int'(SAFETY_COUNT)) begin
            @(negedge sysclk);
            #1 seen |= reg_rdata[STAT_SAFETY_LSB + 1];
        end
        check_bit("axis 2 trip at limit", seen, 1'b0);
        @(negedge sysclk);
        cur_fb[1] = 16'd2065;                  // one count over
        wait_status(STAT_SAFETY_LSB + 1, 1'b1, "axis 2 safety trip", cycles);
        check_bit("axis 2 trip after 4 cycles", cycles == int'(SAFETY_COUNT), 1'b1);
        exp_safe = 4'b0010;
        check_board("tripped");
        @(negedge sysclk);
        cur_fb[1] = '0;
        host_write(4'd0, OFF_STATUS, status_cmd(1'b0, 1'b0, 4'b0010, 4'b0010));
        wait_status(STAT_SAFETY_LSB + 1, 1'b0, "axis 2 trip clear", cycles);
        exp_safe = '0;
        check_board("trip cleared");
    endtask

    task automatic test_rt_block();
        logic [DATA_W-1:0] words [0:4];
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] exp_stat;
        logic hit;
        int cycles;
        for (int i = 0; i < 4; i++) words[i] = $random(seed);
        words[4] = status_cmd(1'b1, 1'b1, 4'hf, 4'b1010);
        exp_pwr = 1'b1;
        exp_amp = 4'b1010;
        exp_stat = status_expect(board_id, exp_pwr, exp_amp, exp_safe);
        for (int i = 0; i <= 4; i++) begin
            @(negedge sysclk);
            rt_wen = 1'b1;
            rt_waddr = 3'(i);
            rt_wdata = words[i];
        end
        @(negedge sysclk);
        rt_wen = 1'b0;
        reg_raddr = make_addr(ADDR_MAIN, 4'd0, OFF_STATUS);
        hit = 1'b0;
        cycles = 0;
        while (!hit && cycles < TIMEOUT) begin  // status is the last replayed word
            @(negedge sysclk);
            #1;
            cycles++;
            hit = (reg_rdata === exp_stat);
        end
        if (!hit) begin
            err_timeout++;
            $display("timeout: status from the real-time block not seen within %0d cycles",
                TIMEOUT);
        end
        for (int a = 1; a <= NUM_AXES; a++) begin
            exp_cmd[a] = words[a - 1][CUR_W-1:0];
            read_reg(ADDR_MAIN, 4'(a), OFF_CMD_CUR, rd);
            check_data($sformatf("rt cmd axis %0d", a), rd, {16'h0, exp_cmd[a]});
        end
        check_board("rt block");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed = 50;
        err_data = 0;
        err_cur = 0;
        err_bit = 0;
        err_timeout = 0;
        rst = 1'b1;
        host_wbus = '0;
        reg_raddr = '0;
        rt_wen = 1'b0;
        rt_waddr = '0;
        rt_wdata = '0;
        cur_fb = '0;
        board_id = 4'ha;
        exp_pwr = 1'b0;
        exp_amp = '0;
        exp_safe = '0;
        repeat (10) @(posedge sysclk);
        @(negedge sysclk);
        rst = 1'b0;
        check_board("after reset");
        test_cmd_regs();
        test_adc_readback();
        test_board_status();
        test_safety();
        test_rt_block();
        $display("errors: data %0d, cur %0d, bit %0d, timeout %0d",
            err_data, err_cur, err_bit, err_timeout);
        if (err_data + err_cur + err_bit + err_timeout == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
source/mc_pkg.sv
source/rt_block_writer.sv
source/axis_regs.sv
source/board_regs.sv
source/safety_check.sv
source/reg_read_mux.sv
source/motor_ctrl_top.sv
tb/tb_motor_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_motor_ctrl -f build.f -o tb_motor_ctrl \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_motor_ctrl > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "run failed, see sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
